// ==== filelist.f ====
spuRegPkg.sv
spuTimingPkg.sv
sampleTimer.sv
voiceSequencer.sv
voiceParamRam.sv
spuBusRegs.sv
spuTop.sv
spuTb.sv

// ==== Makefile ====
# Verilator build and run of the sound core testbench

SRCS := $(shell cat filelist.f)

all: check

# Rebuilt only when a source or the file list changes
obj_dir/VspuTb: filelist.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module spuTb -f filelist.f -o VspuTb

run: obj_dir/VspuTb
	obj_dir/VspuTb | tee sim.log

check: run
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run check clean

// ==== spuTb.sv ====
// ------------------------------
// Testbench for the sound core
//  Clock, reset, LFSR data
//  Wishbone read and write tasks
//  Ack, tick and timeout monitor
//  Readback, key-on, pitch tests
// ------------------------------
`timescale 1ns/1ps

module spuTb import spuRegPkg::*; import spuTimingPkg::*; ();

	localparam int timeoutCycles = 40 * sampleCycles;	// Tests use about 10 periods
	localparam int ackWaitMax    = 4;

	logic        clk;
	logic        n_rst;
	wbReq        bus;
	wbResp       busResp;
	logic        sampleTick;
	logic [31:0] lfsr = 32'h38bd0241;
	int          cycle = 0;		// Clocks since start
	int          lastTick = 0;
	int          tickCount = 0;
	logic        prevAck = 1'b0;
	logic        prevStb = 1'b0;	// Request seen one cycle back
	int          testVoice [3] = '{0, 5, 23};
	regWord      expVoice [3][8];	// Written field values
	regWord      expGlob [3];		// Main L, main R, control

	spuTop spuTop_i (
		.clk        (clk),
		.n_rst      (n_rst),
		.bus        (bus),
		.busResp    (busResp),
		.sampleTick (sampleTick)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;		// 20 ns period
	end

	// Galois LFSR, one step per bit
	function automatic regWord randomWord();
		regWord w;
		for (int i = 0; i < 16; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			w[i] = lfsr[0];
		end
		return w;
	endfunction

	function automatic busAddr voiceAddr(input int v, input logic [2:0] f);
		return busAddr'(v * 16 + f * 2);
	endfunction

	function automatic busAddr globAddr(input logic [4:0] idx);
		return busAddr'(globalBase + idx * 2);
	endfunction

	task automatic abortRun();
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic failValue(input string msg);
		$display("FAIL at %0t ns: %s", $time, msg);
		abortRun();
	endtask

	// ------------------------------
	// Bus access, stb dropped after ack
	// ------------------------------
	task automatic busAccess(input logic we, input busAddr adr, input regWord datW,
			output regWord datR);
		int waited;
		waited = 0;
		@(posedge clk);
		bus.cyc  <= 1'b1;
		bus.stb  <= 1'b1;
		bus.we   <= we;
		bus.adr  <= adr;
		bus.datW <= datW;
		do begin
			@(posedge clk);
			waited++;
			ackLimit: assert (waited <= ackWaitMax) else begin
				$display("No ack within %0d cycles for address %h", ackWaitMax, adr);
				abortRun();
			end
		end while (!busResp.ack);
		ackDelay: assert (waited == 2) else
			failValue($sformatf("ack after %0d cycles, expected 2", waited));
		datR = busResp.datR;		// Valid with ack
		bus.cyc <= 1'b0;
		bus.stb <= 1'b0;
		bus.we  <= 1'b0;
	endtask

	task automatic busWrite(input busAddr adr, input regWord d);
		regWord unused;
		busAccess(1'b1, adr, d, unused);
	endtask

	task automatic checkRead(input busAddr adr, input regWord expected, input string what);
		regWord got;
		busAccess(1'b0, adr, '0, got);
		readValue: assert (got === expected) else
			failValue($sformatf("%s at %h read %h, expected %h", what, adr, got, expected));
	endtask

	// ------------------------------
	// Monitor
	// ------------------------------
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= timeoutCycles) begin
			$display("Timeout, run still going after %0d cycles", cycle);
			abortRun();
		end
		if (n_rst) begin
			ackPair: assert (!(busResp.ack && prevAck)) else failValue("two acks back to back");
			ackCause: assert (!busResp.ack || prevStb) else failValue("ack without a request");
			if (sampleTick) begin
				if (tickCount > 0)
					tickSpacing: assert (cycle - lastTick == sampleCycles) else
						failValue($sformatf("tick %0d cycles after the last", cycle - lastTick));
				lastTick  <= cycle;
				tickCount <= tickCount + 1;
			end
		end
		prevAck <= busResp.ack;
		prevStb <= bus.cyc && bus.stb;
	end

	// ------------------------------
	// Tests
	// ------------------------------
	initial begin
		regWord v;
		regWord p0;
		regWord p1;
		regWord diff;
		int     start;
		bus   = '0;
		n_rst = 1'b0;
		repeat (2) @(posedge clk);
		n_rst <= 1'b1;

		checkRead(voiceAddr(5, fieldPitch), 16'h0000, "pitch after reset");
		foreach (testVoice[i]) begin
			for (int f = 0; f < 8; f++) begin
				if (f != fieldPos) begin
					expVoice[i][f] = randomWord();
					busWrite(voiceAddr(testVoice[i], f[2:0]), expVoice[i][f]);
				end
			end
		end
		expGlob[0] = randomWord();
		expGlob[1] = randomWord();
		expGlob[2] = randomWord() & 16'h7fff;	// Core stays off for now
		v          = randomWord();
		busWrite(globAddr(globMainL), expGlob[0]);
		busWrite(globAddr(globMainR), expGlob[1]);
		busWrite(globAddr(globCtrl), expGlob[2]);
		busWrite(globAddr(globKonHi), v);
		busWrite(globAddr(5'h02), randomWord());	// Unlisted indices
		busWrite(globAddr(5'h1f), randomWord());
		busWrite(11'h1c0, randomWord());		// Voice 28, past both windows
		foreach (testVoice[i]) begin
			for (int f = 0; f < 8; f++) begin
				if (f != fieldPos)
					checkRead(voiceAddr(testVoice[i], f[2:0]), expVoice[i][f],
						$sformatf("voice %0d field %0d", testVoice[i], f));
			end
		end
		checkRead(globAddr(globMainL), expGlob[0], "main volume left");
		checkRead(globAddr(globMainR), expGlob[1], "main volume right");
		checkRead(globAddr(globCtrl), expGlob[2], "control");
		checkRead(globAddr(globKonHi), {8'h00, v[7:0]}, "key-on high");
		checkRead(globAddr(5'h02), 16'h0000, "unlisted global");
		checkRead(globAddr(5'h1f), 16'h0000, "unlisted global");
		checkRead(11'h1c0, 16'h0000, "voice past 23");

		// Disabled core keeps key-on and positions
		busWrite(voiceAddr(3, fieldPitch), 16'h0010);
		busWrite(voiceAddr(20, fieldPitch), 16'h7000);	// Above the clamp
		busWrite(globAddr(globKonLo), 16'h0008);	// Voice 3
		busWrite(globAddr(globKonHi), 16'h0010);	// Voice 20
		repeat (2 * sampleCycles) @(posedge clk);
		checkRead(globAddr(globKonLo), 16'h0008, "key-on low, core off");
		checkRead(globAddr(globKonHi), 16'h0010, "key-on high, core off");
		checkRead(voiceAddr(3, fieldPos), 16'h0000, "voice 3 position, core off");
		checkRead(voiceAddr(20, fieldPos), 16'h0000, "voice 20 position, core off");
		checkRead(voiceAddr(23, fieldPos), 16'h0000, "voice 23 position, core off");

		// Enable, key-on bits must clear
		busWrite(globAddr(globCtrl), 16'h8000);
		start = cycle;
		do begin
			busAccess(1'b0, globAddr(globKonLo), '0, p0);
			busAccess(1'b0, globAddr(globKonHi), '0, p1);
			konDeadline: assert (cycle - start <= 2 * sampleCycles) else begin
				$display("Key-on bits still set two sample periods after enable");
				abortRun();
			end
		end while (p0 != 0 || p1 != 0);
		busAccess(1'b0, voiceAddr(3, fieldPos), '0, p0);
		busAccess(1'b0, voiceAddr(20, fieldPos), '0, p1);
		konStep3: assert (p0 % 16'h0010 == 0) else
			failValue($sformatf("voice 3 position %h not a multiple of 0010", p0));
		konStep20: assert (p1 % 16'h4000 == 0) else
			failValue($sformatf("voice 20 position %h not a multiple of 4000", p1));

		// Pitch step and clamp
		repeat (sampleCycles) @(posedge clk);
		busAccess(1'b0, voiceAddr(3, fieldPos), '0, p1);
		diff = p1 - p0;		// Wraps like the position
		pitchStep: assert (diff != 0 && diff % 16'h0010 == 0) else
			failValue($sformatf("voice 3 moved by %h in one period", diff));
		for (int n = 0; n < 3; n++) begin
			repeat (sampleCycles / 3) @(posedge clk);
			busAccess(1'b0, voiceAddr(20, fieldPos), '0, v);
			clampStep: assert (v % 16'h4000 == 0) else
				failValue($sformatf("voice 20 position %h not a multiple of 4000", v));
		end
		checkRead(voiceAddr(10, fieldPos), 16'h0000, "voice 10 position at pitch 0");
		tickSeen: assert (tickCount >= 2) else failValue("fewer than two sample ticks seen");

		$display("All checks passed");
		$finish;
	end

endmodule

// ==== spuTop.sv ====
// ------------------------------
// Sound processor top level
//  Timer, sequencer, param RAM
//  Bus register block
// ------------------------------
`timescale 1ns/1ps

module spuTop import spuTimingPkg::*; import spuRegPkg::*; (
	input  logic  clk,
	input  logic  n_rst,
	input  wbReq  bus,
	output wbResp busResp,
	output logic  sampleTick
);

	voiceIdx  voice;		// Slot schedule
	slotPhase phase;
	voiceMask keyOn;
	logic     enable;
	voiceCmd  cmd;
	logic     konClearValid;
	voiceIdx  konClearVoice;
	wbReq     voiceReq;
	regWord   voiceData;

	sampleTimer sampleTimer_i (
		.clk        (clk),
		.n_rst      (n_rst),
		.sampleTick (sampleTick),
		.voice      (voice),
		.phase      (phase)
	);

	voiceSequencer voiceSequencer_i (
		.clk           (clk),
		.n_rst         (n_rst),
		.voice         (voice),
		.phase         (phase),
		.keyOn         (keyOn),
		.enable        (enable),
		.cmd           (cmd),
		.konClearValid (konClearValid),
		.konClearVoice (konClearVoice)
	);

	voiceParamRam voiceParamRam_i (
		.clk    (clk),
		.n_rst  (n_rst),
		.req    (voiceReq),
		.rdData (voiceData),
		.cmd    (cmd)
	);

	spuBusRegs spuBusRegs_i (
		.clk           (clk),
		.n_rst         (n_rst),
		.req           (bus),
		.resp          (busResp),
		.voiceReq      (voiceReq),
		.voiceData     (voiceData),
		.keyOn         (keyOn),
		.enable        (enable),
		.konClearValid (konClearValid),
		.konClearVoice (konClearVoice)
	);

endmodule

// ==== spuBusRegs.sv ====
// ------------------------------
// Wishbone slave and global registers
//  Address decode, one wait state ack
//  Main volumes, key-on, control
//  Read data select
// ------------------------------
`timescale 1ns/1ps

module spuBusRegs import spuTimingPkg::*; import spuRegPkg::*; (
	input  logic     clk,
	input  logic     n_rst,
	input  wbReq     req,
	output wbResp    resp,
	output wbReq     voiceReq,
	input  regWord   voiceData,
	output voiceMask keyOn,
	output logic     enable,
	input  logic     konClearValid,
	input  voiceIdx  konClearVoice
);

	logic       ack;
	logic       access;		// First cycle of an access
	logic       isVoice;
	logic       isGlobal;
	logic [4:0] globIdx;

	regWord   mainL;
	regWord   mainR;
	regWord   ctrl;		// Only enable bit is used
	voiceMask kon;

	regWord globRead;
	regWord globData;
	logic   wasVoice;

	// ------------------------------
	// Decode
	// ------------------------------
	assign access   = req.cyc && req.stb && !ack;
	assign isVoice  = (req.adr < voiceAreaEnd);
	assign isGlobal = (req.adr[10:6] == globalBase[10:6]);	// 180h..1BFh
	assign globIdx  = req.adr[5:1];

	// Voice area goes straight through, stb qualified
	always_comb begin
		voiceReq     = req;
		voiceReq.stb = access && isVoice;
	end

	// ------------------------------
	// Ack and global registers
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_rst) begin
			ack   <= 1'b0;
			mainL <= '0;
			mainR <= '0;
			ctrl  <= '0;
			kon   <= '0;
		end else begin
			ack <= access;		// Never two in a row
			if (konClearValid)
				kon[konClearVoice] <= 1'b0;
			// CPU write comes last and wins over the clear
			if (access && req.we && isGlobal) begin
				case (globIdx)
					globMainL: mainL      <= req.datW;
					globMainR: mainR      <= req.datW;
					globKonLo: kon[15:0]  <= req.datW;
					globKonHi: kon[23:16] <= req.datW[7:0];
					globCtrl:  ctrl       <= req.datW;
					default: ;
				endcase
			end
		end
	end

	// ------------------------------
	// Read data
	// ------------------------------
	always_comb begin
		case (globIdx)
			globMainL: globRead = mainL;
			globMainR: globRead = mainR;
			globKonLo: globRead = kon[15:0];
			globKonHi: globRead = {8'h00, kon[23:16]};
			globCtrl:  globRead = ctrl;
			default:   globRead = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (access) begin
			wasVoice <= isVoice;
			globData <= isGlobal ? globRead : '0;	// Outside both areas reads 0
		end
	end

	always_comb begin
		resp.ack  = ack;
		resp.datR = wasVoice ? voiceData : globData;
	end

	assign keyOn  = kon;
	assign enable = ctrl[ctrlEnableBit];

endmodule

// ==== voiceParamRam.sv ====
// ------------------------------
// Per-voice register storage
//  CPU port with read data one cycle later
//  Sequencer port and pitch clamp
//  Position clear or accumulate
// ------------------------------
`timescale 1ns/1ps

module voiceParamRam import spuTimingPkg::*; import spuRegPkg::*; (
	input  logic    clk,
	input  logic    n_rst,
	input  wbReq    req,		// stb already qualified
	output regWord  rdData,
	input  voiceCmd cmd
);

	// Eight fields per voice
	regWord  volL   [numVoices];
	regWord  volR   [numVoices];
	regWord  pitch  [numVoices];
	regWord  start  [numVoices];
	regWord  adsrLo [numVoices];
	regWord  adsrHi [numVoices];
	position pos    [numVoices];	// Owned by the sequencer
	regWord  repAdr [numVoices];

	voiceIdx    cpuVoice;
	logic [2:0] cpuField;
	regWord     cpuData;

	regWord  seqPitch;		// Sequencer read port
	position seqPos;
	regWord  step;
	position nextPos;

	assign cpuVoice = req.adr[8:4];
	assign cpuField = req.adr[3:1];

	// ------------------------------
	// Sequencer side
	// ------------------------------
	always_ff @(posedge clk) begin
		seqPitch <= pitch[cmd.voice];		// Valid in update
		seqPos   <= pos[cmd.voice];
	end

	assign step    = (seqPitch > pitchLimit) ? pitchLimit : seqPitch;
	assign nextPos = cmd.clearPos ? '0 : seqPos + step;	// Wraps at 16 bits

	// ------------------------------
	// Storage writes
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_rst) begin
			for (int i = 0; i < numVoices; i++) begin
				volL[i]   <= '0;
				volR[i]   <= '0;
				pitch[i]  <= '0;
				start[i]  <= '0;
				adsrLo[i] <= '0;
				adsrHi[i] <= '0;
				pos[i]    <= '0;
				repAdr[i] <= '0;
			end
		end else begin
			if (req.stb && req.we) begin
				case (cpuField)
					fieldVolL:   volL[cpuVoice]   <= req.datW;
					fieldVolR:   volR[cpuVoice]   <= req.datW;
					fieldPitch:  pitch[cpuVoice]  <= req.datW;
					fieldStart:  start[cpuVoice]  <= req.datW;
					fieldAdsrLo: adsrLo[cpuVoice] <= req.datW;
					fieldAdsrHi: adsrHi[cpuVoice] <= req.datW;
					fieldRepeat: repAdr[cpuVoice] <= req.datW;
					default: ;	// Position not writable from CPU
				endcase
			end
			if (cmd.we)
				pos[cmd.voice] <= nextPos;	// Update edge
		end
	end

	// ------------------------------
	// CPU read
	// ------------------------------
	always_comb begin
		case (cpuField)
			fieldVolL:   cpuData = volL[cpuVoice];
			fieldVolR:   cpuData = volR[cpuVoice];
			fieldPitch:  cpuData = pitch[cpuVoice];
			fieldStart:  cpuData = start[cpuVoice];
			fieldAdsrLo: cpuData = adsrLo[cpuVoice];
			fieldAdsrHi: cpuData = adsrHi[cpuVoice];
			fieldPos:    cpuData = pos[cpuVoice];
			default:     cpuData = repAdr[cpuVoice];
		endcase
	end

	always_ff @(posedge clk) begin
		if (req.stb)
			rdData <= cpuData;	// Lines up with ack
	end

endmodule

// ==== voiceSequencer.sv ====
// ------------------------------
// Voice sequencer
//  One voice per slot, three cycles
//  Key-on restart or pitch advance
//  Key-on clear back to registers
// ------------------------------
`timescale 1ns/1ps

module voiceSequencer import spuTimingPkg::*; import spuRegPkg::*; (
	input  logic     clk,
	input  logic     n_rst,
	input  voiceIdx  voice,
	input  slotPhase phase,
	input  voiceMask keyOn,
	input  logic     enable,
	output voiceCmd  cmd,
	output logic     konClearValid,
	output voiceIdx  konClearVoice
);

	seqState state;
	voiceIdx curVoice;		// Voice of the slot in flight
	logic    konBit;		// Key-on sampled in fetch

	// ------------------------------
	// State machine
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_rst) begin
			state    <= idle;
			curVoice <= '0;
			konBit   <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (phase == '0) begin		// Slot start
						curVoice <= voice;
						state    <= enable ? fetch : skip;
					end
				end
				fetch: begin
					// Param RAM reads pitch and position this cycle
					konBit <= keyOn[curVoice];
					state  <= update;
				end
				update: state <= idle;	// Write lands at this edge
				skip:   state <= idle;	// Nothing to do this slot
				default: state <= idle;
			endcase
		end
	end

	// ------------------------------
	// Outputs
	// ------------------------------
	always_comb begin
		cmd.voice    = curVoice;
		cmd.we       = (state == update);
		cmd.clearPos = (state == update) && konBit;
	end

	// Serviced key-on goes back to the register block
	assign konClearValid = (state == update) && konBit;
	assign konClearVoice = curVoice;

endmodule

// ==== sampleTimer.sv ====
// ------------------------------
// Sample period timer
//  768 cycle counter
//  Sample tick, voice slot, slot phase
// ------------------------------
`timescale 1ns/1ps

module sampleTimer import spuTimingPkg::*; (
	input  logic     clk,
	input  logic     n_rst,
	output logic     sampleTick,
	output voiceIdx  voice,
	output slotPhase phase
);

	logic [$clog2(sampleCycles)-1:0] counter;	// 0..767
	logic                            lastCycle;

	assign lastCycle = (counter == ($clog2(sampleCycles))'(sampleCycles - 1));

	// ------------------------------
	// Period counter
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_rst) begin
			counter    <= '0;
			sampleTick <= 1'b0;
		end else begin
			counter    <= lastCycle ? '0 : counter + 1'b1;
			sampleTick <= lastCycle;	// High while counter is back at 0
		end
	end

	// Slot size is a power of two, plain bit slices
	assign voice = voiceIdx'(counter / slotCycles);
	assign phase = slotPhase'(counter % slotCycles);

endmodule

// ==== spuTimingPkg.sv ====
// ------------------------------
// Timing side definitions
//  Voice count and cycle counts
//  Voice index and slot phase types
//  Sequencer states, voice command
// ------------------------------
package spuTimingPkg;

	localparam int numVoices   = 24;
	localparam int slotCycles  = 32;			// Clocks per voice slot
	localparam int sampleCycles = numVoices * slotCycles;	// 768 per sample

	typedef logic [4:0] voiceIdx;	// Voice 0..23
	typedef logic [4:0] slotPhase;	// Cycle 0..31 in slot

	// Per slot sequencer
	typedef enum logic [1:0] {
		idle,		// Wait for slot start
		fetch,		// Voice presented to param RAM
		update,		// Position write back
		skip		// Core disabled, slot unused
	} seqState;

	// Sequencer to param RAM
	typedef struct packed {
		voiceIdx voice;
		logic    clearPos;	// Key-on, restart at 0
		logic    we;		// Position write strobe
	} voiceCmd;

endpackage

// ==== spuRegPkg.sv ====
// ------------------------------
// Register side definitions
//  Register and bus value types
//  Voice field and global word indices
//  Address map limits, pitch clamp
//  Wishbone request and response structs
// ------------------------------
package spuRegPkg;

	// ------------------------------
	// Value types
	// ------------------------------
	typedef logic [15:0] regWord;		// One 16 bit register
	typedef logic [10:0] busAddr;		// Byte address, bit 0 unused
	typedef logic [23:0] voiceMask;		// One bit per voice
	typedef logic [15:0] position;		// 4.12 sample position

	// Voice field index, adr bits 3..1
	localparam logic [2:0] fieldVolL   = 3'd0;
	localparam logic [2:0] fieldVolR   = 3'd1;
	localparam logic [2:0] fieldPitch  = 3'd2;
	localparam logic [2:0] fieldStart  = 3'd3;
	localparam logic [2:0] fieldAdsrLo = 3'd4;
	localparam logic [2:0] fieldAdsrHi = 3'd5;
	localparam logic [2:0] fieldPos    = 3'd6;	// Read only
	localparam logic [2:0] fieldRepeat = 3'd7;

	// Global word index, adr bits 5..1
	localparam logic [4:0] globMainL  = 5'h00;
	localparam logic [4:0] globMainR  = 5'h01;
	localparam logic [4:0] globKonLo  = 5'h04;	// Voices 0..15
	localparam logic [4:0] globKonHi  = 5'h05;	// Voices 16..23 in low byte
	localparam logic [4:0] globCtrl   = 5'h16;

	// Address map
	localparam busAddr voiceAreaEnd = 11'h180;	// First byte past voice area
	localparam busAddr globalBase   = 11'h180;	// 64 byte global window

	// Core limits
	localparam regWord pitchLimit    = 16'h4000;	// Max step, 4.0 samples
	localparam int     ctrlEnableBit = 15;

	// ------------------------------
	// Wishbone classic
	// ------------------------------
	typedef struct packed {
		logic   cyc;
		logic   stb;
		logic   we;
		busAddr adr;
		regWord datW;
	} wbReq;

	typedef struct packed {
		logic   ack;
		regWord datR;	// Valid with ack
	} wbResp;

endpackage
